// File: cmd_bridge.f
+incdir+.
cmd_pkg.sv
pwm_pkg.sv
pwm_cfg_if.sv
cmd_parser.sv
pwm_channel.sv
status_uploader.sv
cmd_bridge_top.sv
tb_clk_gen.sv
cmd_bridge_tb.sv

// File: cmd_bridge_tb.sv
`default_nettype none

`include "cmd_bridge_settings.svh"

module cmd_bridge_tb;

    import cmd_pkg::*;

    localparam int UPLOAD_TIMEOUT  = 16;
    localparam int RESET_TIMEOUT   = 16;
    localparam int WATCHDOG_CYCLES = 50000;
    localparam int BURST_LEN       = 5;

    logic                  clk;
    logic                  rst;
    logic [7:0]            usb_data;
    logic                  usb_data_valid;
    logic [7:0]            upload_data;
    logic                  upload_valid;
    logic [`CB_NUM_CH-1:0] pwm;
    logic                  led;

    // expected register contents of every channel
    logic [`CB_CNT_W-1:0]  exp_period [`CB_NUM_CH];
    logic [`CB_CNT_W-1:0]  exp_duty   [`CB_NUM_CH];
    logic                  exp_led;

    tb_clk_gen i_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    cmd_bridge_top i_dut (
        .clk                (clk),
        .rst_i              (rst),
        .usb_data_i         (usb_data),
        .usb_data_valid_i   (usb_data_valid),
        .usb_upload_data_o  (upload_data),
        .usb_upload_valid_o (upload_valid),
        .pwm_o              (pwm),
        .led_o              (led)
    );

    // ==============================
    // error handling
    // ==============================

    task automatic stop_sim();
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string reason);
        $display("%s", reason);
        stop_sim();
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [39:0] exp, input logic [39:0] act);
        assert (act === exp) else begin
            $display("Mismatch in %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
            stop_sim();
        end
    endtask

    // ==============================
    // stimulus and collection
    // ==============================

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        usb_data       = b;
        usb_data_valid = 1'b1;
        @(negedge clk);
        usb_data_valid = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // every complete command flips the led
    task automatic expect_led_toggle(input string test);
        exp_led = ~exp_led;
        check_value(test, "led_o", 40'(exp_led), 40'(led));
    endtask

    task automatic write_field(input string test, input logic [7:0] op,
                               input logic [7:0] ch, input logic [15:0] value);
        send_byte(op);
        send_byte(ch);
        send_byte(value[15:8]);
        send_byte(value[7:0]);
        if (ch < `CB_NUM_CH) begin
            if (op == OP_SET_PERIOD) begin
                exp_period[ch] = value;
            end else begin
                exp_duty[ch] = value;
            end
        end
        expect_led_toggle(test);
    endtask

    task automatic set_enable(input string test, input logic [`CB_NUM_CH-1:0] mask);
        send_byte(OP_ENABLE);
        send_byte(8'(mask));
        expect_led_toggle(test);
    endtask

    task automatic collect_upload(input string test, output logic [39:0] burst);
        int waited;
        waited = 0;
        burst  = '0;
        while (upload_valid !== 1'b1) begin
            if (waited >= UPLOAD_TIMEOUT) begin
                report_error("no upload burst arrived after a read command");
            end
            @(negedge clk);
            waited++;
        end
        // first byte two edges after the last command byte was sampled
        check_value(test, "upload latency in cycles", 40'(1), 40'(waited));
        for (int i = 0; i < BURST_LEN; i++) begin
            assert (upload_valid === 1'b1) else begin
                report_error("upload valid dropped inside a burst");
            end
            burst = {burst[31:0], upload_data};
            @(negedge clk);
        end
        assert (upload_valid === 1'b0) else begin
            report_error("upload burst is longer than five bytes");
        end
    endtask

    task automatic check_readback(input string test, input int ch);
        logic [39:0] burst;
        logic [39:0] expected;
        send_byte(OP_READ);
        send_byte(8'(ch));
        expect_led_toggle(test);
        collect_upload(test, burst);
        expected = {`CB_UPLOAD_MARK, exp_period[ch], exp_duty[ch]};
        check_value(test, $sformatf("readback of channel %0d", ch), expected, burst);
    endtask

    // ==============================
    // directed tests
    // ==============================

    task automatic test_reset_state();
        check_value("reset_state", "pwm_o", 40'(0), 40'(pwm));
        check_value("reset_state", "usb_upload_valid_o", 40'(0), 40'(upload_valid));
        check_value("reset_state", "led_o", 40'(0), 40'(led));
    endtask

    task automatic test_write_readback();
        for (int ch = 0; ch < `CB_NUM_CH; ch++) begin
            write_field("write_readback", OP_SET_PERIOD, 8'(ch), 16'($urandom));
            write_field("write_readback", OP_SET_DUTY, 8'(ch), 16'($urandom));
        end
        for (int ch = 0; ch < `CB_NUM_CH; ch++) begin
            check_readback("write_readback", ch);
        end
    endtask

    task automatic test_duty_count();
        int                    period   [`CB_NUM_CH];
        int                    duty     [`CB_NUM_CH];
        int                    high_cnt [`CB_NUM_CH];
        int                    max_period;
        logic [`CB_NUM_CH-1:0] mask;
        set_enable("duty_count", '0);
        max_period = 0;
        for (int ch = 0; ch < `CB_NUM_CH; ch++) begin
            period[ch]   = 2 + ($urandom % 16);
            duty[ch]     = $urandom % period[ch];
            high_cnt[ch] = 0;
            write_field("duty_count", OP_SET_PERIOD, 8'(ch), 16'(period[ch]));
            write_field("duty_count", OP_SET_DUTY, 8'(ch), 16'(duty[ch]));
            if (period[ch] > max_period) begin
                max_period = period[ch];
            end
        end
        // at least one channel on and one off
        mask                 = `CB_NUM_CH'($urandom) | `CB_NUM_CH'(1);
        mask[`CB_NUM_CH-1]   = 1'b0;
        set_enable("duty_count", mask);
        wait_cycles(max_period + 2);
        for (int cyc = 0; cyc < max_period; cyc++) begin
            @(negedge clk);
            for (int ch = 0; ch < `CB_NUM_CH; ch++) begin
                if (mask[ch]) begin
                    if (cyc < period[ch] && pwm[ch]) begin
                        high_cnt[ch]++;
                    end
                end else begin
                    check_value("duty_count", $sformatf("disabled pwm_o[%0d]", ch),
                                40'(0), 40'(pwm[ch]));
                end
            end
        end
        for (int ch = 0; ch < `CB_NUM_CH; ch++) begin
            if (mask[ch]) begin
                check_value("duty_count", $sformatf("high cycles of pwm_o[%0d]", ch),
                            40'(duty[ch]), 40'(high_cnt[ch]));
            end
        end
    endtask

    task automatic test_edge_cases();
        int period;
        int duty;
        set_enable("edge_cases", '0);
        period = 4 + ($urandom % 12);
        duty   = period + ($urandom % 4);
        // channel 0 saturates and channel 1 has a zero period
        write_field("edge_cases", OP_SET_PERIOD, 8'd0, 16'(period));
        write_field("edge_cases", OP_SET_DUTY, 8'd0, 16'(duty));
        write_field("edge_cases", OP_SET_PERIOD, 8'd1, 16'd0);
        write_field("edge_cases", OP_SET_DUTY, 8'd1, 16'd3);
        set_enable("edge_cases", `CB_NUM_CH'(8'h03));
        wait_cycles(period + 2);
        for (int cyc = 0; cyc < 2 * period; cyc++) begin
            @(negedge clk);
            check_value("edge_cases", "saturated pwm_o[0]", 40'(1), 40'(pwm[0]));
            check_value("edge_cases", "zero period pwm_o[1]", 40'(0), 40'(pwm[1]));
        end
        // switch channel 0 off while it runs
        set_enable("edge_cases", `CB_NUM_CH'(8'h02));
        @(negedge clk);
        for (int cyc = 0; cyc < period; cyc++) begin
            check_value("edge_cases", "disabled pwm_o[0]", 40'(0), 40'(pwm[0]));
            check_value("edge_cases", "zero period pwm_o[1]", 40'(0), 40'(pwm[1]));
            @(negedge clk);
        end
    endtask

    task automatic test_bad_commands();
        // channel 0 runs saturated so a stray write shows on its pin
        set_enable("bad_commands", '0);
        write_field("bad_commands", OP_SET_PERIOD, 8'd0, 16'd6);
        write_field("bad_commands", OP_SET_DUTY, 8'd0, 16'd6);
        set_enable("bad_commands", `CB_NUM_CH'(8'h01));
        send_byte(8'h00);
        send_byte(8'h5A);
        send_byte(8'hFF);
        check_value("bad_commands", "led_o after unknown opcodes", 40'(exp_led), 40'(led));
        // 8'hF8 would alias channel 0 on its low bits
        write_field("bad_commands", OP_SET_DUTY, 8'd9, 16'h1234);
        write_field("bad_commands", OP_SET_PERIOD, 8'hF8, 16'hBEEF);
        send_byte(OP_READ);
        send_byte(8'd8);
        expect_led_toggle("bad_commands");
        for (int cyc = 0; cyc < UPLOAD_TIMEOUT; cyc++) begin
            check_value("bad_commands", "usb_upload_valid_o", 40'(0), 40'(upload_valid));
            check_value("bad_commands", "pwm_o", 40'(8'h01), 40'(pwm));
            @(negedge clk);
        end
        for (int ch = 0; ch < `CB_NUM_CH; ch++) begin
            check_readback("bad_commands", ch);
        end
        check_value("bad_commands", "pwm_o", 40'(8'h01), 40'(pwm));
        // parser must still accept a valid command
        write_field("bad_commands", OP_SET_DUTY, 8'd3, 16'($urandom));
        check_readback("bad_commands", 3);
    endtask

    // ==============================
    // run control
    // ==============================

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_error("simulation ran too long and was stopped by the watchdog");
    end

    initial begin : main
        int waited;
        usb_data       = 8'h00;
        usb_data_valid = 1'b0;
        exp_led        = 1'b0;
        for (int ch = 0; ch < `CB_NUM_CH; ch++) begin
            exp_period[ch] = '0;
            exp_duty[ch]   = '0;
        end
        void'($urandom(32'h4914_a761));

        waited = 0;
        while (rst !== 1'b0) begin
            if (waited >= RESET_TIMEOUT) begin
                report_error("reset was never released");
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);

        test_reset_state();
        test_write_readback();
        test_duty_count();
        test_edge_cases();
        test_bad_commands();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset spans RST_CYCLES rising edges and drops on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: cmd_bridge_top.sv
`default_nettype none

`include "cmd_bridge_settings.svh"

module cmd_bridge_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [7:0]            usb_data_i,
    input  logic                  usb_data_valid_i,
    output logic [7:0]            usb_upload_data_o,
    output logic                  usb_upload_valid_o,
    output logic [`CB_NUM_CH-1:0] pwm_o,
    output logic                  led_o
);

    import pwm_pkg::*;

    pwm_cfg_if  cfg_bus ();
    pwm_cfg_t   views [`CB_NUM_CH];
    logic       rd_req;
    logic [2:0] rd_ch;

    // ==============================
    // command decode
    // ==============================

    cmd_parser i_parser (
        .clk              (clk),
        .rst_i            (rst_i),
        .usb_data_i       (usb_data_i),
        .usb_data_valid_i (usb_data_valid_i),
        .cfg              (cfg_bus.master),
        .rd_req_o         (rd_req),
        .rd_ch_o          (rd_ch),
        .led_o            (led_o)
    );

    // one generator per output pin
    for (genvar i = 0; i < `CB_NUM_CH; i++) begin : g_ch
        pwm_channel #(
            .CH_INDEX (i)
        ) i_ch (
            .clk    (clk),
            .rst_i  (rst_i),
            .cfg    (cfg_bus.channel),
            .view_o (views[i]),
            .pwm_o  (pwm_o[i])
        );
    end

    // readback path back toward the usb core
    status_uploader i_uploader (
        .clk            (clk),
        .rst_i          (rst_i),
        .views_i        (views),
        .rd_req_i       (rd_req),
        .rd_ch_i        (rd_ch),
        .upload_data_o  (usb_upload_data_o),
        .upload_valid_o (usb_upload_valid_o)
    );

endmodule

`default_nettype wire

// File: status_uploader.sv
`default_nettype none

`include "cmd_bridge_settings.svh"

module status_uploader (
    input  logic              clk,
    input  logic              rst_i,
    input  pwm_pkg::pwm_cfg_t views_i [`CB_NUM_CH],
    input  logic              rd_req_i,
    input  logic [2:0]        rd_ch_i,
    output logic [7:0]        upload_data_o,
    output logic              upload_valid_o
);

    import pwm_pkg::*;

    // marker, period hi, period lo, duty hi, duty lo
    localparam int BURST_LEN = 5;

    pwm_cfg_t   hold_q;
    logic [2:0] byte_cnt_q;
    logic [7:0] next_byte;
    logic       busy;
    logic       start;

    // counter value is the number of bytes already on the bus
    assign busy  = (byte_cnt_q != 3'd0);
    assign start = rd_req_i && !busy;

    // snapshot of the selected channel
    always_ff @(posedge clk) begin
        if (start) begin
            hold_q <= views_i[rd_ch_i];
        end
    end

    always_comb begin
        case (byte_cnt_q)
            3'd1:    next_byte = hold_q.period[`CB_CNT_W-1 -: 8];
            3'd2:    next_byte = hold_q.period[7:0];
            3'd3:    next_byte = hold_q.duty[`CB_CNT_W-1 -: 8];
            default: next_byte = hold_q.duty[7:0];
        endcase
    end

    // ==============================
    // burst sequencer
    // ==============================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            byte_cnt_q     <= 3'd0;
            upload_data_o  <= 8'h00;
            upload_valid_o <= 1'b0;
        end else if (start) begin
            upload_data_o  <= `CB_UPLOAD_MARK;
            upload_valid_o <= 1'b1;
            byte_cnt_q     <= 3'd1;
        end else if (busy) begin
            if (byte_cnt_q == 3'(BURST_LEN)) begin
                // last byte has been shown
                upload_data_o  <= 8'h00;
                upload_valid_o <= 1'b0;
                byte_cnt_q     <= 3'd0;
            end else begin
                upload_data_o <= next_byte;
                byte_cnt_q    <= byte_cnt_q + 3'd1;
            end
        end
    end

    // a read request landing mid-burst is lost
    a_no_req_busy: assert property (
        @(posedge clk) disable iff (rst_i) rd_req_i |-> !busy
    ) else $error("status_uploader: read request dropped, upload still running");

    // every accepted request yields exactly five valid bytes
    a_burst_len: assert property (
        @(posedge clk) disable iff (rst_i)
        start |=> upload_valid_o [*BURST_LEN] ##1 !upload_valid_o
    ) else $error("status_uploader: upload burst length is not five bytes");

endmodule

`default_nettype wire

// File: pwm_channel.sv
`default_nettype none

`include "cmd_bridge_settings.svh"

module pwm_channel #(
    parameter int CH_INDEX = 0
) (
    input  logic              clk,
    input  logic              rst_i,
    pwm_cfg_if.channel        cfg,
    output pwm_pkg::pwm_cfg_t view_o,
    output logic              pwm_o
);

    import pwm_pkg::*;

    logic [`CB_CNT_W-1:0] pend_period_q;
    logic [`CB_CNT_W-1:0] pend_duty_q;
    logic [`CB_CNT_W-1:0] act_period_q;
    logic [`CB_CNT_W-1:0] act_duty_q;
    logic [`CB_CNT_W-1:0] cnt_q;
    logic                 en_q;
    logic                 sel;
    logic                 last;

    assign sel  = cfg.cfg_we && (cfg.cfg_ch == 3'(CH_INDEX));
    // zero period counts as a wrap on every cycle
    assign last = (act_period_q == '0) || (cnt_q == act_period_q - 1'b1);

    // pending registers and enable bit
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pend_period_q <= '0;
            pend_duty_q   <= '0;
            en_q          <= 1'b0;
        end else begin
            if (sel) begin
                if (cfg.cfg_field == FLD_PERIOD) begin
                    pend_period_q <= cfg.cfg_value;
                end else begin
                    pend_duty_q <= cfg.cfg_value;
                end
            end
            if (cfg.en_we) begin
                en_q <= cfg.en_mask[CH_INDEX];
            end
        end
    end

    // active values follow pending at wrap or while off
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q        <= '0;
            act_period_q <= '0;
            act_duty_q   <= '0;
        end else if (!en_q || last) begin
            cnt_q        <= '0;
            act_period_q <= pend_period_q;
            act_duty_q   <= pend_duty_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign pwm_o  = en_q && (act_period_q != '0) && (cnt_q < act_duty_q);

    // readback shows what was written, not what is running
    assign view_o = '{period: pend_period_q, duty: pend_duty_q, en: en_q};

    a_cnt_in_range: assert property (
        @(posedge clk) disable iff (rst_i) (act_period_q != '0) |-> (cnt_q < act_period_q)
    ) else $error("pwm_channel %0d: counter reached the active period", CH_INDEX);

endmodule

`default_nettype wire

// File: cmd_parser.sv
`default_nettype none

`include "cmd_bridge_settings.svh"

module cmd_parser (
    input  logic       clk,
    input  logic       rst_i,
    input  logic [7:0] usb_data_i,
    input  logic       usb_data_valid_i,
    pwm_cfg_if.master  cfg,
    output logic       rd_req_o,
    output logic [2:0] rd_ch_o,
    output logic       led_o
);

    import cmd_pkg::*;
    import pwm_pkg::*;

    parser_state_t state_q;
    opcode_t       op_q;
    logic [2:0]    ch_q;
    logic          ch_ok_q;
    logic [7:0]    hi_q;
    logic          chan_in_range;

    // one channel range check shared by every consumer
    assign chan_in_range = (usb_data_i < `CB_NUM_CH);

    // ==============================
    // command payload capture
    // ==============================

    always_ff @(posedge clk) begin
        if (usb_data_valid_i) begin
            case (state_q)
                ST_OPCODE: begin
                    op_q <= opcode_t'(usb_data_i);
                end
                ST_CHAN: begin
                    ch_q    <= usb_data_i[2:0];
                    ch_ok_q <= chan_in_range;
                end
                ST_HI: begin
                    hi_q <= usb_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    // ==============================
    // byte walker and strobes
    // ==============================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q       <= ST_OPCODE;
            cfg.cfg_we    <= 1'b0;
            cfg.cfg_ch    <= '0;
            cfg.cfg_field <= FLD_PERIOD;
            cfg.cfg_value <= '0;
            cfg.en_we     <= 1'b0;
            cfg.en_mask   <= '0;
            rd_req_o      <= 1'b0;
            rd_ch_o       <= '0;
            led_o         <= 1'b0;
        end else begin
            // strobes last a single cycle
            cfg.cfg_we <= 1'b0;
            cfg.en_we  <= 1'b0;
            rd_req_o   <= 1'b0;

            if (usb_data_valid_i) begin
                case (state_q)
                    ST_OPCODE: begin
                        case (usb_data_i)
                            OP_SET_PERIOD, OP_SET_DUTY, OP_READ: state_q <= ST_CHAN;
                            OP_ENABLE: state_q <= ST_MASK;
                            // unknown opcode is dropped
                            default: state_q <= ST_OPCODE;
                        endcase
                    end
                    ST_CHAN: begin
                        if (op_q == OP_READ) begin
                            // read completes on the channel byte
                            rd_req_o <= chan_in_range;
                            rd_ch_o  <= usb_data_i[2:0];
                            led_o    <= ~led_o;
                            state_q  <= ST_OPCODE;
                        end else begin
                            state_q <= ST_HI;
                        end
                    end
                    ST_HI: begin
                        state_q <= ST_LO;
                    end
                    ST_LO: begin
                        // bad channel still counts as a complete command
                        cfg.cfg_we    <= ch_ok_q;
                        cfg.cfg_ch    <= ch_q;
                        cfg.cfg_field <= (op_q == OP_SET_PERIOD) ? FLD_PERIOD : FLD_DUTY;
                        cfg.cfg_value <= {hi_q, usb_data_i};
                        led_o         <= ~led_o;
                        state_q       <= ST_OPCODE;
                    end
                    ST_MASK: begin
                        cfg.en_we   <= 1'b1;
                        cfg.en_mask <= usb_data_i[`CB_NUM_CH-1:0];
                        led_o       <= ~led_o;
                        state_q     <= ST_OPCODE;
                    end
                    default: begin
                        state_q <= ST_OPCODE;
                    end
                endcase
            end
        end
    end

    // one command never drives both the channels and the uploader
    a_single_strobe: assert property (
        @(posedge clk) disable iff (rst_i) !(cfg.cfg_we && rd_req_o)
    ) else $error("cmd_parser: config write and read request in the same cycle");

endmodule

`default_nettype wire

// File: pwm_cfg_if.sv
`default_nettype none

`include "cmd_bridge_settings.svh"

interface pwm_cfg_if;

    import pwm_pkg::*;

    // single register write with a one cycle strobe
    logic                  cfg_we;
    logic [2:0]            cfg_ch;
    pwm_field_t            cfg_field;
    logic [`CB_CNT_W-1:0]  cfg_value;

    // enable mask update for all channels at once
    logic                  en_we;
    logic [`CB_NUM_CH-1:0] en_mask;

    // parser side drives everything
    modport master (
        output cfg_we,
        output cfg_ch,
        output cfg_field,
        output cfg_value,
        output en_we,
        output en_mask
    );

    modport channel (
        input cfg_we,
        input cfg_ch,
        input cfg_field,
        input cfg_value,
        input en_we,
        input en_mask
    );

endinterface

`default_nettype wire

// File: pwm_pkg.sv
`default_nettype none

`include "cmd_bridge_settings.svh"

package pwm_pkg;

    // ==============================
    // pwm channel register types
    // ==============================

    // which shadow register a write targets
    typedef enum logic {
        FLD_PERIOD = 1'b0,
        FLD_DUTY   = 1'b1
    } pwm_field_t;

    // register view of one channel as seen by readback
    typedef struct packed {
        logic [`CB_CNT_W-1:0] period;
        logic [`CB_CNT_W-1:0] duty;
        logic                 en;
    } pwm_cfg_t;

endpackage

`default_nettype wire

// File: cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    // ==============================
    // command stream encodings
    // ==============================

    // opcode byte values on the usb stream
    typedef enum logic [7:0] {
        // channel, period high, period low
        OP_SET_PERIOD = 8'h01,
        // channel, duty high, duty low
        OP_SET_DUTY   = 8'h02,
        // one mask byte where bit n enables channel n
        OP_ENABLE     = 8'h03,
        // channel byte that an upload burst answers
        OP_READ       = 8'h04
    } opcode_t;

    // parser position inside a command
    typedef enum logic [2:0] {
        ST_OPCODE = 3'd0,
        ST_CHAN   = 3'd1,
        ST_HI     = 3'd2,
        ST_LO     = 3'd3,
        ST_MASK   = 3'd4
    } parser_state_t;

endpackage

`default_nettype wire

// File: cmd_bridge_settings.svh
`ifndef CMD_BRIDGE_SETTINGS_SVH
`define CMD_BRIDGE_SETTINGS_SVH

// ==============================
// bridge build settings
// ==============================

// number of identical PWM channels
`define CB_NUM_CH 8

// width of period, duty and counter values
// the upload burst sends two bytes per value, so keep this at 16
`define CB_CNT_W 16

// first byte of every readback burst
`define CB_UPLOAD_MARK 8'hA5

`endif
